/* reservoir_asic.f */
reservoir_pkg.sv
adc_spi_reader.sv
dac_spi_writer.sv
reservoir_core.sv
reservoir_asic.sv
analog_loop_model.sv
reservoir_assertions.sv
tb_reservoir_asic.sv

/* Makefile */
TOP = tb_reservoir_asic

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f reservoir_asic.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f reservoir_asic.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb_reservoir_asic.sv */
`timescale 1ns/1ps

module tb_reservoir_asic;
    import reservoir_pkg::*;

    localparam int NUM_STEPS      = 24;
    localparam int TIMEOUT_CYCLES = 400;

    logic                    clk;
    logic                    rst;
    logic                    en;
    logic [DATA_WIDTH-1:0]   din;
    logic                    adc_dout;
    logic [DATA_WIDTH-1:0]   dout;
    logic                    reservoir_valid;
    logic                    dac_cs_n;
    logic                    dac_ldac_n;
    logic                    dac_din;
    logic                    dac_sclk;
    logic                    adc_cs_n;
    logic                    adc_sclk;
    logic [SAMPLE_WIDTH-1:0] applied_code;
    int                      frame_count;
    int                      frame_errors;

    logic [DATA_WIDTH-1:0]   step_din [NUM_STEPS];
    bit                      step_hold [NUM_STEPS]; // Keep en high into the next step.
    logic [SAMPLE_WIDTH-1:0] ref_ring [VIRTUAL_NODES];
    int                      checks;
    int                      errors;

    reservoir_asic dut (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .din             (din),
        .adc_dout        (adc_dout),
        .dout            (dout),
        .reservoir_valid (reservoir_valid),
        .dac_cs_n        (dac_cs_n),
        .dac_ldac_n      (dac_ldac_n),
        .dac_din         (dac_din),
        .dac_sclk        (dac_sclk),
        .adc_cs_n        (adc_cs_n),
        .adc_sclk        (adc_sclk)
    );

    analog_loop_model u_loop (
        .dac_cs_n     (dac_cs_n),
        .dac_ldac_n   (dac_ldac_n),
        .dac_sclk     (dac_sclk),
        .dac_din      (dac_din),
        .adc_cs_n     (adc_cs_n),
        .adc_sclk     (adc_sclk),
        .adc_dout     (adc_dout),
        .applied_code (applied_code),
        .frame_count  (frame_count),
        .frame_errors (frame_errors)
    );

    bind reservoir_asic reservoir_assertions u_assertions (
        .clk             (clk),
        .rst             (rst),
        .reservoir_valid (reservoir_valid),
        .dac_cs_n        (dac_cs_n),
        .dac_ldac_n      (dac_ldac_n),
        .dac_sclk        (dac_sclk),
        .adc_cs_n        (adc_cs_n),
        .adc_sclk        (adc_sclk)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                               input logic [DATA_WIDTH-1:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic fill_table();
        step_din[0] = 32'h0000_0000;
        step_din[1] = 32'hFFFF_FFFF;
        step_din[2] = 32'h8000_0000;
        step_din[3] = 32'h7FFF_FFFF;
        step_din[4] = 32'h000F_FFFF; // Only below the code bits.
        step_din[5] = 32'hFFF0_0000;
        for (int i = 6; i < NUM_STEPS; i++) begin
            step_din[i] = $urandom();
        end
        for (int i = 0; i < NUM_STEPS; i++) begin
            step_hold[i] = (i == 2) || (i == 9) || (i == 10) || (i == 17);
        end
    endtask

    // Top twelve bits of din plus the last node.
    function automatic logic [SAMPLE_WIDTH-1:0] predict_code(input logic [DATA_WIDTH-1:0] value);
        logic [DATA_WIDTH-1:0] total;
        total = value + {ref_ring[VIRTUAL_NODES-1], 20'h0_0000};
        return total[DATA_WIDTH-1:DATA_WIDTH-SAMPLE_WIDTH];
    endfunction

    function automatic logic [SAMPLE_WIDTH-1:0] node_response(input logic [SAMPLE_WIDTH-1:0] code);
        return (code >> 1) + 12'h400;
    endfunction

    task automatic push_ring(input logic [SAMPLE_WIDTH-1:0] value);
        for (int i = VIRTUAL_NODES - 1; i > 0; i--) begin
            ref_ring[i] = ref_ring[i-1];
        end
        ref_ring[0] = value;
    endtask

    // Busy first, then valid again.
    task automatic wait_step_end(output bit ok);
        int cycles;
        bit saw_busy;
        cycles   = 0;
        saw_busy = 1'b0;
        ok       = 1'b0;
        while (cycles < TIMEOUT_CYCLES && !ok) begin
            @(posedge clk);
            cycles++;
            if (!reservoir_valid) begin
                saw_busy = 1'b1;
            end else if (saw_busy) begin
                ok = 1'b1;
            end
        end
    endtask

    initial begin
        bit                      chained;
        bit                      ok;
        bit                      timed_out;
        int                      steps_done;
        logic [SAMPLE_WIDTH-1:0] exp_code;
        checks     = 0;
        errors     = 0;
        steps_done = 0;
        timed_out  = 1'b0;
        chained    = 1'b0;
        rst        = 1'b1;
        en         = 1'b0;
        din        = '0;
        void'($urandom(32'h485e_abf3));
        fill_table();
        for (int i = 0; i < VIRTUAL_NODES; i++) begin
            ref_ring[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("dout", dout, '0);
        check_value("reservoir_valid", DATA_WIDTH'(reservoir_valid), 1);
        check_value("dac_cs_n", DATA_WIDTH'(dac_cs_n), 1);
        check_value("adc_cs_n", DATA_WIDTH'(adc_cs_n), 1);
        check_value("dac_ldac_n", DATA_WIDTH'(dac_ldac_n), 1);
        check_value("dac_sclk", DATA_WIDTH'(dac_sclk), 0);
        check_value("adc_sclk", DATA_WIDTH'(adc_sclk), 0);
        check_value("dac_din", DATA_WIDTH'(dac_din), 0);

        for (int i = 0; i < NUM_STEPS && !timed_out; i++) begin
            if (!chained) begin
                @(posedge clk);
                en  <= 1'b1;
                din <= step_din[i];
                @(posedge clk); // Core starts the step here.
            end
            // din moves away from the latched value.
            if (step_hold[i] && i + 1 < NUM_STEPS) begin
                din <= step_din[i+1];
            end else begin
                en  <= 1'b0;
                din <= ~step_din[i];
            end
            exp_code = predict_code(step_din[i]);
            push_ring(node_response(exp_code));
            wait_step_end(ok);
            if (!ok) begin
                timed_out = 1'b1;
                errors++;
                $display("Timeout: step %0d did not finish within %0d cycles", i, TIMEOUT_CYCLES);
            end else begin
                steps_done++;
                check_value("applied_code", DATA_WIDTH'(applied_code), DATA_WIDTH'(exp_code));
                check_value("dout", dout, {ref_ring[VIRTUAL_NODES-1], 20'h0_0000});
            end
            chained = step_hold[i] && (i + 1 < NUM_STEPS);
        end

        en <= 1'b0;
        @(posedge clk);
        check_value("frame_errors", frame_errors, 0);
        check_value("frame_count", frame_count, steps_done);
        $display("Summary: %0d checks, %0d errors, %0d steps", checks, errors, steps_done);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* reservoir_assertions.sv */
`timescale 1ns/1ps

module reservoir_assertions (
    input logic clk,
    input logic rst,
    input logic reservoir_valid,
    input logic dac_cs_n,
    input logic dac_ldac_n,
    input logic dac_sclk,
    input logic adc_cs_n,
    input logic adc_sclk
);

    dac_sclk_idle: assert property (@(posedge clk) disable iff (rst) dac_cs_n |-> !dac_sclk)
        else $error("DAC SCLK high while DAC chip select is high");

    adc_sclk_idle: assert property (@(posedge clk) disable iff (rst) adc_cs_n |-> !adc_sclk)
        else $error("ADC SCLK high while ADC chip select is high");

    // Load strobe only between frames.
    ldac_outside_frame: assert property (@(posedge clk) disable iff (rst)
        !dac_ldac_n |-> dac_cs_n)
        else $error("DAC LDAC low during a DAC frame");

    one_device_selected: assert property (@(posedge clk) disable iff (rst)
        dac_cs_n || adc_cs_n)
        else $error("DAC and ADC selected at the same time");

    busy_during_frame: assert property (@(posedge clk) disable iff (rst)
        (!dac_cs_n || !adc_cs_n) |-> !reservoir_valid)
        else $error("reservoir_valid high during an SPI frame");

endmodule

/* analog_loop_model.sv */
`timescale 1ns/1ps

module analog_loop_model (
    input  logic                                   dac_cs_n,
    input  logic                                   dac_ldac_n,
    input  logic                                   dac_sclk,
    input  logic                                   dac_din,
    input  logic                                   adc_cs_n,
    input  logic                                   adc_sclk,
    output logic                                   adc_dout,
    output logic [reservoir_pkg::SAMPLE_WIDTH-1:0] applied_code,
    output int                                     frame_count,
    output int                                     frame_errors
);
    import reservoir_pkg::*;

    logic [SPI_FRAME_BITS-1:0] dac_frame = '0;
    logic [SAMPLE_WIDTH-1:0]   held_code = '0;
    logic [SAMPLE_WIDTH-1:0]   node_level = '0; // Stage output seen by the ADC.
    logic [SPI_FRAME_BITS-1:0] adc_word;
    logic [BIT_CNT_W-1:0]      fall_count = '0;
    logic                      sclk_high = 1'b0;
    int                        bit_count = 0;
    int                        frames = 0;
    int                        bad_frames = 0;
    bit                        in_frame = 1'b0;

    // DAC input register, shifted on rising SCLK while CS is low.
    always @(posedge dac_sclk or negedge dac_cs_n or posedge dac_cs_n) begin
        if (dac_cs_n === 1'b0 && !in_frame) begin
            in_frame  = 1'b1;
            bit_count = 0;
        end else if (dac_cs_n === 1'b1 && in_frame) begin
            in_frame = 1'b0;
            frames++;
            if (bit_count != SPI_FRAME_BITS || dac_frame[SPI_FRAME_BITS-1 -: 4] != DAC_CMD) begin
                bad_frames++;
            end
        end else if (in_frame && dac_sclk === 1'b1) begin
            dac_frame = {dac_frame[SPI_FRAME_BITS-2:0], dac_din};
            bit_count++;
        end
    end

    // LDAC moves the code to the output and through the stage.
    always @(negedge dac_ldac_n) begin
        held_code  = dac_frame[SAMPLE_WIDTH-1:0];
        node_level = (held_code >> 1) + 12'h400;
    end

    // Sixteen falls per frame, so the counter wraps at the frame end.
    always @(adc_sclk) begin
        if (adc_sclk === 1'b1) begin
            sclk_high = 1'b1;
        end else if (adc_sclk === 1'b0 && sclk_high) begin
            sclk_high  = 1'b0;
            fall_count = fall_count + 1'b1;
        end
    end

    assign adc_word     = {4'b0000, node_level};
    assign adc_dout     = adc_cs_n ? 1'b0 : adc_word[BIT_LAST - fall_count];
    assign applied_code = held_code;
    assign frame_count  = frames;
    assign frame_errors = bad_frames;

endmodule

/* reservoir_asic.sv */
`timescale 1ns/1ps

module reservoir_asic (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 en,
    input  logic [reservoir_pkg::DATA_WIDTH-1:0] din,
    input  logic                                 adc_dout,
    output logic [reservoir_pkg::DATA_WIDTH-1:0] dout,
    output logic                                 reservoir_valid,
    output logic                                 dac_cs_n,
    output logic                                 dac_ldac_n,
    output logic                                 dac_din,
    output logic                                 dac_sclk,
    output logic                                 adc_cs_n,
    output logic                                 adc_sclk
);
    import reservoir_pkg::*;

    logic                    dac_start;
    logic [SAMPLE_WIDTH-1:0] dac_code;
    logic                    dac_done;
    logic                    adc_start;
    logic                    sample_valid;
    logic [SAMPLE_WIDTH-1:0] sample;

    reservoir_core u_core (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .din             (din),
        .dac_done        (dac_done),
        .sample_valid    (sample_valid),
        .sample          (sample),
        .dout            (dout),
        .reservoir_valid (reservoir_valid),
        .dac_start       (dac_start),
        .dac_code        (dac_code),
        .adc_start       (adc_start)
    );

    // Drives the node nonlinearity input.
    dac_spi_writer u_dac (
        .clk    (clk),
        .rst    (rst),
        .start  (dac_start),
        .code   (dac_code),
        .cs_n   (dac_cs_n),
        .ldac_n (dac_ldac_n),
        .sclk   (dac_sclk),
        .sdo    (dac_din),
        .done   (dac_done)
    );

    adc_spi_reader u_adc (
        .clk          (clk),
        .rst          (rst),
        .start        (adc_start),
        .sdi          (adc_dout),
        .cs_n         (adc_cs_n),
        .sclk         (adc_sclk),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

/* reservoir_core.sv */
`timescale 1ns/1ps

module reservoir_core (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   en,
    input  logic [reservoir_pkg::DATA_WIDTH-1:0]   din,
    input  logic                                   dac_done,
    input  logic                                   sample_valid,
    input  logic [reservoir_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic [reservoir_pkg::DATA_WIDTH-1:0]   dout,
    output logic                                   reservoir_valid,
    output logic                                   dac_start,
    output logic [reservoir_pkg::SAMPLE_WIDTH-1:0] dac_code,
    output logic                                   adc_start
);
    import reservoir_pkg::*;

    step_state_t             state;
    logic [DATA_WIDTH-1:0]   sum;
    logic                    step_go;
    logic                    ring_shift;

    // Virtual node chain, node 0 takes the newest sample.
    logic [SAMPLE_WIDTH-1:0] ring [VIRTUAL_NODES];

    assign reservoir_valid = (state == ST_UPDATE);
    assign step_go         = reservoir_valid && en;
    assign ring_shift      = (state == ST_READ_ADC) && sample_valid;

    // Last node feeds back through the top bits of dout.
    assign dout = {ring[VIRTUAL_NODES-1], {(DATA_WIDTH - SAMPLE_WIDTH){1'b0}}};
    assign sum  = din + dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_UPDATE;
            dac_start <= 1'b0;
            adc_start <= 1'b0;
        end else begin
            dac_start <= 1'b0;
            adc_start <= 1'b0;
            case (state)
                ST_UPDATE: begin
                    if (en) begin
                        state     <= ST_WRITE_DAC;
                        dac_start <= 1'b1;
                    end
                end
                ST_WRITE_DAC: begin
                    if (dac_done) begin
                        state     <= ST_READ_ADC;
                        adc_start <= 1'b1;
                    end
                end
                ST_READ_ADC: begin
                    if (sample_valid) begin
                        state <= ST_UPDATE; // Step settled.
                    end
                end
                default: begin
                    state <= ST_UPDATE;
                end
            endcase
        end
    end

    // Held for the whole step so din may move.
    always_ff @(posedge clk) begin
        if (step_go) begin
            dac_code <= sum[DATA_WIDTH-1 -: SAMPLE_WIDTH];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < VIRTUAL_NODES; i++) begin
                ring[i] <= '0;
            end
        end else if (ring_shift) begin
            ring[0] <= sample;
            for (int i = 1; i < VIRTUAL_NODES; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

endmodule

/* dac_spi_writer.sv */
`timescale 1ns/1ps

module dac_spi_writer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [reservoir_pkg::SAMPLE_WIDTH-1:0] code,
    output logic                                   cs_n,
    output logic                                   ldac_n,
    output logic                                   sclk,
    output logic                                   sdo,
    output logic                                   done
);
    import reservoir_pkg::*;

    logic                      shifting;
    logic                      loading;
    logic                      idle;
    logic [SCLK_CNT_W-1:0]     div_cnt;
    logic [BIT_CNT_W-1:0]      bit_cnt;
    logic [SPI_FRAME_BITS-1:0] shift_reg; // MSB mirrors sdo.
    logic                      launch;
    logic                      next_bit;

    assign idle   = !shifting && !loading;
    assign launch = idle && start;

    // Falling SCLK that moves on to another bit.
    assign next_bit = shifting && sclk && (div_cnt == SCLK_LAST) && (bit_cnt != BIT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_n     <= 1'b1;
            ldac_n   <= 1'b1;
            sclk     <= 1'b0;
            sdo      <= 1'b0;
            done     <= 1'b0;
            shifting <= 1'b0;
            loading  <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                cs_n     <= 1'b0;
                shifting <= 1'b1;
                sdo      <= DAC_CMD[3];
                div_cnt  <= '0;
                bit_cnt  <= '0;
            end else if (shifting) begin
                if (div_cnt != SCLK_LAST) begin
                    div_cnt <= div_cnt + 1'b1;
                end else begin
                    div_cnt <= '0;
                    if (!sclk) begin
                        sclk <= 1'b1; // DAC samples here.
                    end else begin
                        sclk <= 1'b0;
                        if (bit_cnt == BIT_LAST) begin
                            cs_n     <= 1'b1;
                            sdo      <= 1'b0;
                            shifting <= 1'b0;
                            loading  <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sdo     <= shift_reg[SPI_FRAME_BITS-2];
                        end
                    end
                end
            end else if (loading) begin
                // One idle cycle with CS high, then LDAC low.
                if (ldac_n) begin
                    ldac_n  <= 1'b0;
                    div_cnt <= '0;
                end else if (div_cnt == SCLK_LAST) begin
                    ldac_n  <= 1'b1;
                    loading <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            shift_reg <= {DAC_CMD, code};
        end else if (next_bit) begin
            shift_reg <= {shift_reg[SPI_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

/* adc_spi_reader.sv */
`timescale 1ns/1ps

module adc_spi_reader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic                                 sdi,
    output logic                                 cs_n,
    output logic                                 sclk,
    output logic [reservoir_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                                 sample_valid
);
    import reservoir_pkg::*;

    logic                    active;
    logic [SCLK_CNT_W-1:0]   div_cnt;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [SAMPLE_WIDTH-1:0] capture; // Leading zeros fall off the top.
    logic                    rise_edge;

    // High on the cycle that drives SCLK high.
    assign rise_edge = active && !sclk && (div_cnt == SCLK_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_n         <= 1'b1;
            sclk         <= 1'b0;
            active       <= 1'b0;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (!active) begin
                if (start) begin
                    cs_n    <= 1'b0;
                    active  <= 1'b1;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (div_cnt != SCLK_LAST) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                if (!sclk) begin
                    sclk <= 1'b1; // Sample point.
                end else begin
                    sclk <= 1'b0;
                    if (bit_cnt == BIT_LAST) begin
                        // Frame complete.
                        cs_n         <= 1'b1;
                        active       <= 1'b0;
                        sample_valid <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rise_edge) begin
            capture <= {capture[SAMPLE_WIDTH-2:0], sdi};
        end
    end

    assign sample = capture;

endmodule

/* reservoir_pkg.sv */
package reservoir_pkg;

    // Datapath widths.
    localparam int DATA_WIDTH   = 32;
    localparam int SAMPLE_WIDTH = 12; // DAC code, ADC sample and node width.

    localparam int VIRTUAL_NODES = 10;

    // SPI framing, shared by DAC and ADC.
    localparam int SPI_FRAME_BITS = 16;
    localparam int SCLK_DIV       = 2; // System clocks per SCLK half period.

    localparam int SCLK_CNT_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_CNT_W  = $clog2(SPI_FRAME_BITS);

    // Last count of each counter.
    localparam logic [SCLK_CNT_W-1:0] SCLK_LAST = SCLK_CNT_W'(SCLK_DIV - 1);
    localparam logic [BIT_CNT_W-1:0]  BIT_LAST  = BIT_CNT_W'(SPI_FRAME_BITS - 1);

    // Write input register, hold output until LDAC.
    localparam logic [3:0] DAC_CMD = 4'b0011;

    // Step sequencing of the reservoir core.
    typedef enum logic [1:0] {
        ST_UPDATE,
        ST_WRITE_DAC,
        ST_READ_ADC
    } step_state_t;

endpackage
